// File: source/vector_io_pkg.sv
package vector_io_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////
	localparam int PORT_W     = 8;              // I/O port number, same as 8080 IN/OUT
	localparam int DATA_W     = 8;
	localparam int AXI_DATA_W = 32;             // Only lane 0 is live
	localparam int STRB_W     = AXI_DATA_W / 8;
	localparam int BORDER_W   = 4;
	localparam int PAL_DEPTH  = 1 << BORDER_W;  // One palette entry per border index

	//////////////////////////////////////////////////
	// Request queue
	//////////////////////////////////////////////////
	localparam int QUEUE_DEPTH = 4;
	localparam int PTR_W       = $clog2(QUEUE_DEPTH);
	localparam int CNT_W       = PTR_W + 1;
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(QUEUE_DEPTH - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(QUEUE_DEPTH);

	// Entry layout {write, port, data, strobe}
	localparam int ENTRY_W      = 1 + PORT_W + DATA_W + 1;
	localparam int ENT_WRITE    = ENTRY_W - 1;
	localparam int ENT_PORT_LSB = DATA_W + 1;
	localparam int ENT_DATA_LSB = 1;
	localparam int ENT_STRB     = 0;

	//////////////////////////////////////////////////
	// Port map
	//////////////////////////////////////////////////
	// Parallel interface, address order reversed against the chip
	localparam logic [PORT_W-1:0] PORT_CTRL    = 8'h00;
	localparam logic [PORT_W-1:0] PORT_C       = 8'h01;  // LEDs and control bits
	localparam logic [PORT_W-1:0] PORT_B       = 8'h02;  // Border index, 512 mode
	localparam logic [PORT_W-1:0] PORT_A       = 8'h03;  // Scroll register
	localparam logic [PORT_W-1:0] PORT_PALETTE = 8'h0C;
	localparam logic [PORT_W-1:0] PORT_RAMDISK = 8'h10;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: source/axil_io_front.sv
`timescale 1ns/100ps

module axil_io_front (
	input  logic                                 clk24,
	input  logic                                 RESET_n,

	// Write address and data
	input  logic [vector_io_pkg::PORT_W-1:0]     awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [vector_io_pkg::AXI_DATA_W-1:0] wdata,
	input  logic [vector_io_pkg::STRB_W-1:0]     wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,

	// Read address
	input  logic [vector_io_pkg::PORT_W-1:0]     araddr,
	input  logic                                 arvalid,
	output logic                                 arready,

	// Queue side
	input  logic                                 full,
	output logic                                 push,
	output logic [vector_io_pkg::ENTRY_W-1:0]    push_entry
);

	logic wr_accept;     // Drives awready and wready together
	logic rd_accept;
	logic last_wr_won;   // Winner of the last write/read conflict
	logic wr_req;
	logic rd_req;
	logic idle;
	logic wr_pick;
	logic rd_pick;

	//////////////////////////////////////////////////
	// Arbitration
	//////////////////////////////////////////////////
	assign wr_req = awvalid & wvalid;   // Both halves of a write present
	assign rd_req = arvalid;

	// Valid still shows during a pulse, so decide only between pulses.
	// With no push in the deciding cycle the queue cannot be full at the handshake.
	assign idle = !wr_accept && !rd_accept && !full;

	// On a conflict the loser of the last one goes first
	assign wr_pick = idle && wr_req && (!rd_req || !last_wr_won);
	assign rd_pick = idle && rd_req && (!wr_req || last_wr_won);

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			wr_accept   <= 1'b0;
			rd_accept   <= 1'b0;
			last_wr_won <= 1'b0;
		end else begin
			wr_accept <= wr_pick;   // One cycle pulse
			rd_accept <= rd_pick;
			if (idle && wr_req && rd_req)
				last_wr_won <= wr_pick;
		end
	end

	//////////////////////////////////////////////////
	// Queue entry
	//////////////////////////////////////////////////
	// Payload is latched with the decision and pushed during the handshake
	always_ff @(posedge clk24) begin
		if (wr_pick) begin
			push_entry <= {1'b1, awaddr, wdata[vector_io_pkg::DATA_W-1:0], wstrb[0]};
		end else if (rd_pick) begin
			push_entry <= {1'b0, araddr, {vector_io_pkg::DATA_W{1'b0}}, 1'b0};
		end
	end

	assign push    = wr_accept | rd_accept;
	assign awready = wr_accept;
	assign wready  = wr_accept;
	assign arready = rd_accept;

endmodule

// File: source/io_cycle_queue.sv
`timescale 1ns/100ps

module io_cycle_queue (
	input  logic                              clk24,
	input  logic                              RESET_n,

	input  logic                              push,
	input  logic [vector_io_pkg::ENTRY_W-1:0] push_entry,
	output logic                              full,

	input  logic                              pop,
	output logic                              valid,
	output logic [vector_io_pkg::ENTRY_W-1:0] pop_entry
);

	logic [vector_io_pkg::ENTRY_W-1:0] mem [vector_io_pkg::QUEUE_DEPTH];
	logic [vector_io_pkg::PTR_W-1:0]   wr_ptr;
	logic [vector_io_pkg::PTR_W-1:0]   rd_ptr;
	logic [vector_io_pkg::CNT_W-1:0]   count;
	logic                              do_push;
	logic                              do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && valid;

	// Entry storage
	always_ff @(posedge clk24) begin
		if (do_push)
			mem[wr_ptr] <= push_entry;
	end

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == vector_io_pkg::PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == vector_io_pkg::PTR_LAST) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Both or neither
			endcase
		end
	end

	assign full      = (count == vector_io_pkg::CNT_FULL);
	assign valid     = (count != '0);
	assign pop_entry = mem[rd_ptr];   // Head of queue

endmodule

// File: source/io_port_file.sv
`timescale 1ns/100ps

module io_port_file (
	input  logic                                 clk24,
	input  logic                                 RESET_n,

	// Queue side
	input  logic                                 valid,
	output logic                                 pop,
	input  logic [vector_io_pkg::ENTRY_W-1:0]    pop_entry,

	// AXI4-Lite responses
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	output logic [vector_io_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0]                           rresp,
	output logic                                 rvalid,
	input  logic                                 rready,

	// Device outputs
	output logic [vector_io_pkg::DATA_W-1:0]     video_scroll,
	output logic [vector_io_pkg::BORDER_W-1:0]   border_index,
	output logic                                 mode512,
	output logic [vector_io_pkg::DATA_W-1:0]     port_c,
	output logic [vector_io_pkg::DATA_W-1:0]     ramdisk_ctrl
);

	logic                              ent_write;
	logic                              ent_strb;
	logic [vector_io_pkg::PORT_W-1:0]  ent_port;
	logic [vector_io_pkg::DATA_W-1:0]  ent_data;
	logic                              ppi_sel;
	logic [1:0]                        ppi_reg;
	logic                              pal_sel;
	logic                              rdk_sel;
	logic                              mapped;
	logic                              slot_free;
	logic                              do_write;
	logic [vector_io_pkg::DATA_W-1:0]  reg_a;
	logic [vector_io_pkg::DATA_W-1:0]  reg_b;
	logic [vector_io_pkg::DATA_W-1:0]  reg_c;
	logic [vector_io_pkg::DATA_W-1:0]  reg_rdk;
	logic [vector_io_pkg::DATA_W-1:0]  palette [vector_io_pkg::PAL_DEPTH];
	logic [vector_io_pkg::DATA_W-1:0]  rd_byte;

	assign ent_write = pop_entry[vector_io_pkg::ENT_WRITE];
	assign ent_strb  = pop_entry[vector_io_pkg::ENT_STRB];
	assign ent_port  = pop_entry[vector_io_pkg::ENT_PORT_LSB +: vector_io_pkg::PORT_W];
	assign ent_data  = pop_entry[vector_io_pkg::ENT_DATA_LSB +: vector_io_pkg::DATA_W];

	//////////////////////////////////////////////////
	// Port decode
	//////////////////////////////////////////////////
	// Upper six bits pick the device, low two are inverted into the register
	assign ppi_sel = ent_port[7:2] == vector_io_pkg::PORT_CTRL[7:2];
	assign ppi_reg = ~ent_port[1:0];
	assign pal_sel = ent_port == vector_io_pkg::PORT_PALETTE;   // 0Dh-0Fh not fitted
	assign rdk_sel = ent_port == vector_io_pkg::PORT_RAMDISK;
	assign mapped  = ppi_sel | pal_sel | rdk_sel;

	always_comb begin
		rd_byte = '0;   // Control port and unmapped ports read 0
		if (ppi_sel) begin
			case (ppi_reg)
				~vector_io_pkg::PORT_A[1:0]: rd_byte = reg_a;
				~vector_io_pkg::PORT_B[1:0]: rd_byte = reg_b;
				~vector_io_pkg::PORT_C[1:0]: rd_byte = reg_c;
				default:                     rd_byte = '0;
			endcase
		end else if (pal_sel) begin
			rd_byte = palette[border_index];
		end else if (rdk_sel) begin
			rd_byte = reg_rdk;
		end
	end

	//////////////////////////////////////////////////
	// Device registers
	//////////////////////////////////////////////////
	assign do_write = pop && ent_write && ent_strb;

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			reg_a   <= '0;
			reg_b   <= '0;
			reg_c   <= '0;
			reg_rdk <= '0;
			for (int i = 0; i < vector_io_pkg::PAL_DEPTH; i++)
				palette[i] <= '0;
		end else if (do_write) begin
			if (ppi_sel) begin
				case (ppi_reg)
					~vector_io_pkg::PORT_A[1:0]: reg_a <= ent_data;
					~vector_io_pkg::PORT_B[1:0]: reg_b <= ent_data;
					~vector_io_pkg::PORT_C[1:0]: reg_c <= ent_data;
					default: begin
						if (ent_data[7]) begin   // Mode word
							reg_a <= '0;
							reg_b <= '0;
							reg_c <= '0;
						end else begin
							reg_c[ent_data[3:1]] <= ent_data[0];   // Bit set/reset
						end
					end
				endcase
			end else if (pal_sel) begin
				palette[border_index] <= ent_data;
			end else if (rdk_sel) begin
				reg_rdk <= ent_data;
			end
		end
	end

	assign video_scroll = reg_a;
	assign border_index = reg_b[vector_io_pkg::BORDER_W-1:0];
	assign mode512      = reg_b[4];
	assign port_c       = reg_c;
	assign ramdisk_ctrl = reg_rdk;

	//////////////////////////////////////////////////
	// Response slot
	//////////////////////////////////////////////////
	// Free when empty or being taken this cycle
	assign slot_free = !(bvalid && !bready) && !(rvalid && !rready);
	assign pop       = valid && slot_free;

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (bready)
				bvalid <= 1'b0;
			if (rready)
				rvalid <= 1'b0;
			if (pop) begin
				bvalid <= ent_write;
				rvalid <= !ent_write;
			end
		end
	end

	always_ff @(posedge clk24) begin
		if (pop && ent_write)
			bresp <= mapped ? vector_io_pkg::RESP_OKAY : vector_io_pkg::RESP_SLVERR;
		if (pop && !ent_write) begin
			rresp <= mapped ? vector_io_pkg::RESP_OKAY : vector_io_pkg::RESP_SLVERR;
			rdata <= {{(vector_io_pkg::AXI_DATA_W - vector_io_pkg::DATA_W){1'b0}}, rd_byte};
		end
	end

endmodule

// File: source/vector_io_top.sv
`timescale 1ns/100ps

module vector_io_top (
	input  logic                                 clk24,
	input  logic                                 RESET_n,

	input  logic [vector_io_pkg::PORT_W-1:0]     awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [vector_io_pkg::AXI_DATA_W-1:0] wdata,
	input  logic [vector_io_pkg::STRB_W-1:0]     wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	input  logic [vector_io_pkg::PORT_W-1:0]     araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	output logic [vector_io_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0]                           rresp,
	output logic                                 rvalid,
	input  logic                                 rready,

	output logic [vector_io_pkg::DATA_W-1:0]     video_scroll,
	output logic [vector_io_pkg::BORDER_W-1:0]   border_index,
	output logic                                 mode512,
	output logic [vector_io_pkg::DATA_W-1:0]     port_c,
	output logic [vector_io_pkg::DATA_W-1:0]     ramdisk_ctrl
);

	logic                              push;
	logic [vector_io_pkg::ENTRY_W-1:0] push_entry;
	logic                              full;
	logic                              q_valid;    // Queue holds a cycle
	logic                              pop;
	logic [vector_io_pkg::ENTRY_W-1:0] pop_entry;

	// Bus side, turns AXI requests into I/O cycles
	axil_io_front front0 (
		.clk24(clk24), .RESET_n(RESET_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.full(full), .push(push), .push_entry(push_entry)
	);

	io_cycle_queue queue0 (
		.clk24(clk24), .RESET_n(RESET_n),
		.push(push), .push_entry(push_entry), .full(full),
		.pop(pop), .valid(q_valid), .pop_entry(pop_entry)
	);

	// Port devices and responses
	io_port_file ports0 (
		.clk24(clk24), .RESET_n(RESET_n),
		.valid(q_valid), .pop(pop), .pop_entry(pop_entry),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.video_scroll(video_scroll), .border_index(border_index), .mode512(mode512),
		.port_c(port_c), .ramdisk_ctrl(ramdisk_ctrl)
	);

endmodule

// File: test/vector_io_properties.sv
`timescale 1ns/100ps

module vector_io_properties (
	input logic                                 clk24,
	input logic                                 RESET_n,
	input logic                                 awready,
	input logic                                 wready,
	input logic                                 arready,
	input logic [1:0]                           bresp,
	input logic                                 bvalid,
	input logic                                 bready,
	input logic [vector_io_pkg::AXI_DATA_W-1:0] rdata,
	input logic [1:0]                           rresp,
	input logic                                 rvalid,
	input logic                                 rready
);

	int assert_fails = 0;   // Failed assertions over the whole run

	// Write response held until taken
	b_hold: assert property (@(posedge clk24) disable iff (!RESET_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			assert_fails++;
			$error("bvalid dropped or bresp changed before its handshake");
		end

	r_hold: assert property (@(posedge clk24) disable iff (!RESET_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else begin
			assert_fails++;
			$error("rvalid dropped or read payload changed before its handshake");
		end

	// Bus quiet right after a reset cycle
	reset_quiet: assert property (@(posedge clk24)
		!RESET_n |=> !(awready || wready || arready || bvalid || rvalid))
		else begin
			assert_fails++;
			$error("ready or valid output high after reset");
		end

	aw_w_pair: assert property (@(posedge clk24) disable iff (!RESET_n) awready == wready)
		else begin
			assert_fails++;
			$error("awready and wready differ");
		end

endmodule

bind vector_io_top vector_io_properties props0 (
	.clk24(clk24), .RESET_n(RESET_n),
	.awready(awready), .wready(wready), .arready(arready),
	.bresp(bresp), .bvalid(bvalid), .bready(bready),
	.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
);

// File: test/tb_vector_io.sv
`timescale 1ns/100ps

module tb_vector_io;

	localparam int NUM_OPS    = 400;
	localparam int CLK_PERIOD = 100;
	localparam int TIMEOUT_NS = NUM_OPS * 20 * CLK_PERIOD;   // 20 cycles per operation

	logic                                 clk24 = 1'b0;
	logic                                 RESET_n = 1'b0;
	logic [vector_io_pkg::PORT_W-1:0]     awaddr = '0;
	logic                                 awvalid = 1'b0;
	logic                                 awready;
	logic [vector_io_pkg::AXI_DATA_W-1:0] wdata = '0;
	logic [vector_io_pkg::STRB_W-1:0]     wstrb = '0;
	logic                                 wvalid = 1'b0;
	logic                                 wready;
	logic [1:0]                           bresp;
	logic                                 bvalid;
	logic                                 bready = 1'b0;
	logic [vector_io_pkg::PORT_W-1:0]     araddr = '0;
	logic                                 arvalid = 1'b0;
	logic                                 arready;
	logic [vector_io_pkg::AXI_DATA_W-1:0] rdata;
	logic [1:0]                           rresp;
	logic                                 rvalid;
	logic                                 rready = 1'b0;
	logic [7:0]                           video_scroll;
	logic [3:0]                           border_index;
	logic                                 mode512;
	logic [7:0]                           port_c;
	logic [7:0]                           ramdisk_ctrl;

	// Reference model state
	logic [7:0]  m_a = '0;
	logic [7:0]  m_b = '0;
	logic [7:0]  m_c = '0;
	logic [7:0]  m_rdk = '0;
	logic [7:0]  m_pal [vector_io_pkg::PAL_DEPTH];
	// Expected responses in acceptance order
	logic        exp_write [$];
	logic [1:0]  exp_resp [$];
	logic [7:0]  exp_data [$];
	logic [28:0] exp_state [$];
	int          errors = 0;
	int          accepted = 0;
	int          responses = 0;
	int          conflicts = 0;        // Write/read pairs seen by the arbiter
	logic        last_winner_wr = 1'b0;

	vector_io_top dut0 (
		.clk24(clk24), .RESET_n(RESET_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.video_scroll(video_scroll), .border_index(border_index), .mode512(mode512),
		.port_c(port_c), .ramdisk_ctrl(ramdisk_ctrl)
	);

	always #(CLK_PERIOD / 2) clk24 = ~clk24;

	// {scroll, border, mode512, port C, ramdisk}
	function automatic logic [28:0] model_state();
		return {m_a, m_b[3:0], m_b[4], m_c, m_rdk};
	endfunction

	// Mapped ports most of the time
	function automatic logic [7:0] pick_port();
		int pick;
		pick = $urandom_range(0, 7);
		case (pick)
			0: return vector_io_pkg::PORT_CTRL;
			1: return vector_io_pkg::PORT_C;
			2: return vector_io_pkg::PORT_B;
			3: return vector_io_pkg::PORT_A;
			4: return vector_io_pkg::PORT_PALETTE;
			5: return vector_io_pkg::PORT_RAMDISK;
			default: return 8'($urandom);   // Mostly unmapped
		endcase
	endfunction

	function automatic logic [7:0] pick_data(input logic [7:0] port);
		logic [7:0] data;
		data = 8'($urandom);
		if (port == vector_io_pkg::PORT_CTRL)
			data[7] = $urandom_range(0, 3) == 0;   // Keep mode words rare
		return data;
	endfunction

	//////////////////////////////////////////////////
	// Reference model for one I/O cycle per call
	//////////////////////////////////////////////////
	task automatic apply_cycle(input logic wr, input logic [7:0] port, input logic [7:0] data,
			input logic strb);
		logic       upd;
		logic [1:0] resp;
		logic [7:0] rd;
		upd  = wr && strb;   // Strobe 0 clear leaves state alone
		resp = vector_io_pkg::RESP_OKAY;
		rd   = '0;
		case (port)
			vector_io_pkg::PORT_A: begin
				if (upd) m_a = data;
				rd = m_a;
			end
			vector_io_pkg::PORT_B: begin
				if (upd) m_b = data;
				rd = m_b;
			end
			vector_io_pkg::PORT_C: begin
				if (upd) m_c = data;
				rd = m_c;
			end
			vector_io_pkg::PORT_CTRL: begin
				if (upd && data[7]) begin   // Mode word
					m_a = '0;
					m_b = '0;
					m_c = '0;
				end else if (upd) begin
					m_c[data[3:1]] = data[0];
				end
			end
			vector_io_pkg::PORT_PALETTE: begin
				if (upd) m_pal[m_b[3:0]] = data;
				rd = m_pal[m_b[3:0]];
			end
			vector_io_pkg::PORT_RAMDISK: begin
				if (upd) m_rdk = data;
				rd = m_rdk;
			end
			default: resp = vector_io_pkg::RESP_SLVERR;   // Reads give 0
		endcase
		exp_write.push_back(wr);
		exp_resp.push_back(resp);
		exp_data.push_back(wr ? 8'h00 : rd);
		exp_state.push_back(model_state());
		accepted++;
	endtask

	task automatic idle_gap();
		int gap;
		gap = $urandom_range(0, 2);
		repeat (gap) begin
			@(posedge clk24);
			#1;
		end
	endtask

	// Called 1 ns after a rising edge and returns at the same point
	task automatic issue_request(input logic wr, input logic [7:0] port, input logic [31:0] wd,
			input logic [3:0] strb);
		if (wr) begin
			awaddr  = port;
			wdata   = wd;
			wstrb   = strb;
			awvalid = 1'b1;
			wvalid  = 1'b1;
		end else begin
			araddr  = port;
			arvalid = 1'b1;
		end
		do @(negedge clk24); while (!(wr ? awready : arready));
		apply_cycle(wr, port, wd[7:0], strb[0]);
		@(posedge clk24);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		arvalid = 1'b0;
		idle_gap();
	endtask

	// Each pair is one conflict, so the winners alternate
	task automatic check_winner(input logic took_wr);
		if (conflicts > 0 && took_wr == last_winner_wr) begin
			$display("[FAIL] %0t: %s won two conflicts in a row", $time,
				took_wr ? "write" : "read");
			errors++;
		end
		last_winner_wr = took_wr;
		conflicts++;
	endtask

	// Write and read raised in the same cycle so the arbiter has to pick
	task automatic issue_pair(input logic [7:0] wport, input logic [31:0] wd,
			input logic [3:0] strb, input logic [7:0] rport);
		logic wr_done;
		logic rd_done;
		logic took_wr;
		wr_done = 1'b0;
		rd_done = 1'b0;
		awaddr  = wport;
		wdata   = wd;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		araddr  = rport;
		arvalid = 1'b1;
		while (!(wr_done && rd_done)) begin
			do @(negedge clk24); while (!awready && !arready);
			took_wr = awready;
			if (!wr_done && !rd_done)
				check_winner(took_wr);
			if (took_wr)
				apply_cycle(1'b1, wport, wd[7:0], strb[0]);
			else
				apply_cycle(1'b0, rport, 8'h00, 1'b0);
			@(posedge clk24);
			#1;
			if (took_wr) begin
				awvalid = 1'b0;
				wvalid  = 1'b0;
				wr_done = 1'b1;
			end else begin
				arvalid = 1'b0;
				rd_done = 1'b1;
			end
		end
		idle_gap();
	endtask

	task automatic check_response(input logic wr, input logic [1:0] resp,
			input logic [31:0] data);
		logic       e_wr;
		logic [1:0] e_resp;
		logic [7:0] e_data;
		logic [28:0] e_state;
		responses++;
		if (exp_write.size() == 0) begin
			$display("Response at %0t arrived with no request outstanding", $time);
			errors++;
		end else begin
			e_wr    = exp_write.pop_front();
			e_resp  = exp_resp.pop_front();
			e_data  = exp_data.pop_front();
			e_state = exp_state.pop_front();
			if (wr != e_wr) begin
				$display("[FAIL] %0t: response type write=%b, expected write=%b", $time, wr, e_wr);
				errors++;
			end
			if (resp != e_resp) begin
				$display("[FAIL] %0t: resp %b, expected %b", $time, resp, e_resp);
				errors++;
			end
			if (!wr && data != {24'h0, e_data}) begin
				$display("[FAIL] %0t: rdata %h, expected %h", $time, data, e_data);
				errors++;
			end
			if ({video_scroll, border_index, mode512, port_c, ramdisk_ctrl} != e_state) begin
				$display("[FAIL] %0t: device outputs %h, expected %h", $time,
					{video_scroll, border_index, mode512, port_c, ramdisk_ctrl}, e_state);
				errors++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Response side
	//////////////////////////////////////////////////
	always @(posedge clk24) begin
		#1;
		bready = $urandom_range(0, 3) != 0;   // Random back-pressure
		rready = $urandom_range(0, 3) != 0;
	end

	// Sampled mid-cycle so the handshake lands on the next edge
	always @(negedge clk24) begin
		if (RESET_n && bvalid && bready)
			check_response(1'b1, bresp, '0);
		if (RESET_n && rvalid && rready)
			check_response(1'b0, rresp, rdata);
	end

	initial begin
		logic       wr;
		logic [7:0] port;
		logic [7:0] data;
		logic [3:0] strb;
		void'($urandom(32'h027e3a40));
		for (int i = 0; i < vector_io_pkg::PAL_DEPTH; i++)
			m_pal[i] = '0;
		repeat (4) @(posedge clk24);
		#1;
		RESET_n = 1'b1;
		for (int n = 0; n < NUM_OPS; n++) begin
			wr   = $urandom_range(0, 1) == 1;
			port = pick_port();
			data = pick_data(port);
			strb = 4'($urandom);
			if ($urandom_range(0, 3) != 0)
				strb[0] = 1'b1;
			if (n < NUM_OPS - 1 && $urandom_range(0, 4) == 0) begin
				issue_pair(port, {24'($urandom), data}, strb, pick_port());
				n++;   // A pair is two operations
			end else begin
				issue_request(wr, port, {24'($urandom), data}, strb);
			end
		end
		while (exp_write.size() != 0)
			@(posedge clk24);
		repeat (4) @(posedge clk24);
		@(negedge clk24);
		if ({video_scroll, border_index, mode512, port_c, ramdisk_ctrl} != model_state()) begin
			$display("[FAIL] %0t: final device outputs differ from the model", $time);
			errors++;
		end
		if (responses != accepted) begin
			$display("Got %0d responses for %0d accepted requests", responses, accepted);
			errors++;
		end
		$display("Requests: %0d, responses: %0d, errors: %0d, assertion failures: %0d",
			accepted, responses, errors, dut0.props0.assert_fails);
		if (errors == 0 && dut0.props0.assert_fails == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: all.f
source/vector_io_pkg.sv
source/axil_io_front.sv
source/io_cycle_queue.sv
source/io_port_file.sv
source/vector_io_top.sv
test/vector_io_properties.sv
test/tb_vector_io.sv

// File: run.sh
#!/bin/sh
# Compile and run the vector_io testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_vector_io -f all.f -o sim_vector_io
out=$(./obj_dir/sim_vector_io) || true
echo "$out"
if echo "$out" | grep -q "TEST PASSED"; then
	exit 0
fi
exit 1
